/* sim.f */
+incdir+.
rv_ctrl_pkg.sv
dec_if.sv
insn_decode.sv
operand_forward.sv
ctrl_issue.sv
rv_ctrl_top.sv
tb_rv_ctrl.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_ctrl -f sim.f
	./obj_dir/Vtb_rv_ctrl | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_rv_ctrl_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control path directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_RV_CTRL_TASKS_SVH
`define TB_RV_CTRL_TASKS_SVH

// Zero immediates apart from funct7 bit 30, the only one decoded
function automatic rv_ctrl_pkg::instr_t enc(input logic [4:0] opc, input logic [4:0] rd,
    input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2, input logic b30);
  enc = {1'b0, b30, 5'b0, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic rv_ctrl_pkg::alu_op_t alu_of(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    alu_of = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
    3'd1:    alu_of = rv_ctrl_pkg::ALU_SLL;
    3'd2:    alu_of = rv_ctrl_pkg::ALU_SLT;
    3'd3:    alu_of = rv_ctrl_pkg::ALU_SLTU;
    3'd4:    alu_of = rv_ctrl_pkg::ALU_XOR;
    3'd5:    alu_of = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
    3'd6:    alu_of = rv_ctrl_pkg::ALU_OR;
    default: alu_of = rv_ctrl_pkg::ALU_AND;
  endcase
endfunction

function automatic rv_ctrl_pkg::fwd_sel_t fwd_of(input logic used,
                                                 input rv_ctrl_pkg::reg_idx_t rs);
  if (!used || rs == 5'd0 || !m_prev_we || m_prev_rd != rs) begin
    fwd_of = rv_ctrl_pkg::FWD_REG;
  end else begin
    fwd_of = m_prev_load ? rv_ctrl_pkg::FWD_MEM : rv_ctrl_pkg::FWD_ALU;
  end
endfunction

// Builds the expected word and advances the model's previous insn
task automatic expect_word(input rv_ctrl_pkg::instr_t instr);
  logic [4:0]            opc;
  logic [2:0]            f3;
  rv_ctrl_pkg::alu_op_t  alu;
  rv_ctrl_pkg::wb_sel_t  wb;
  rv_ctrl_pkg::ldx_t     ldx;
  rv_ctrl_pkg::fwd_sel_t f1;
  rv_ctrl_pkg::fwd_sel_t f2;
  logic                  a_pc, b_imm, we, br_un, u1, u2;
  opc = instr[6:2];
  f3 = instr[14:12];
  {alu, a_pc, b_imm, wb, we, ldx, br_un, u1, u2} = {rv_ctrl_pkg::ALU_ADD, 1'b0, 1'b1,
      rv_ctrl_pkg::WB_ALU, 1'b1, rv_ctrl_pkg::LDX_W, 1'b0, 1'b1, 1'b0};
  case (opc)
    `RV_OPC_RTYPE: begin
      alu = alu_of(f3, instr[30]);
      b_imm = 1'b0;
      u2 = 1'b1;
    end
    `RV_OPC_ITYPE: alu = alu_of(f3, instr[30] && f3 == `RV_FNC_SRL_SRA);  // SRAI only
    `RV_OPC_LOAD: begin
      wb = rv_ctrl_pkg::WB_MEM;
      case (f3)
        `RV_FNC_LB:  ldx = rv_ctrl_pkg::LDX_B;
        `RV_FNC_LH:  ldx = rv_ctrl_pkg::LDX_H;
        `RV_FNC_LBU: ldx = rv_ctrl_pkg::LDX_BU;
        `RV_FNC_LHU: ldx = rv_ctrl_pkg::LDX_HU;
        default:     ldx = rv_ctrl_pkg::LDX_W;
      endcase
    end
    `RV_OPC_STORE: {we, u2} = 2'b01;
    `RV_OPC_BRANCH: begin
      {a_pc, we, u2} = 3'b101;
      br_un = (f3 == `RV_FNC_BLTU) || (f3 == `RV_FNC_BGEU);
    end
    `RV_OPC_JAL: begin
      {a_pc, u1} = 2'b10;
      wb = rv_ctrl_pkg::WB_PC4;
    end
    `RV_OPC_JALR:  wb = rv_ctrl_pkg::WB_PC4;
    `RV_OPC_AUIPC: {a_pc, u1} = 2'b10;
    `RV_OPC_LUI:   u1 = 1'b0;
    default: {alu, a_pc, b_imm, wb, we, ldx, br_un, u1, u2} = '0;  // Empty word
  endcase
  f1 = fwd_of(u1, instr[19:15]);
  f2 = fwd_of(u2, instr[24:20]);
  exp_q.push_back({alu, a_pc, b_imm, wb, we, ldx, br_un, f1, f2, we ? instr[11:7] : 5'd0});
  m_prev_rd = instr[11:7];
  m_prev_we = we;
  m_prev_load = (opc == `RV_OPC_LOAD);
endtask

task automatic send(input rv_ctrl_pkg::instr_t instr);
  int t;
  t = 0;
  while (!in_ready && t < 50) begin
    @(negedge clk);
    t++;
  end
  if (!in_ready) begin
    $display("%s: timeout waiting for in_ready", cur_test);
    errors++;
  end else begin
    expect_word(instr);
    acc_q.push_back(cyc);               // Cycle of the handshake
    in_valid = 1'b1;
    in_instr = instr;
    @(negedge clk);
    in_valid = 1'b0;
  end
endtask

task automatic drain();
  int t;
  t = 0;
  while (exp_q.size() > 0 && t < 200) begin
    @(negedge clk);
    t++;
  end
  if (exp_q.size() > 0) begin
    $display("%s: timeout, %0d control words never issued", cur_test, exp_q.size());
    errors++;
    exp_q.delete();
    acc_q.delete();
  end
endtask

task automatic chk_fwd(input rv_ctrl_pkg::fwd_sel_t e1, input rv_ctrl_pkg::fwd_sel_t e2);
  drain();
  if (ctrl_fwd_rs1 !== e1 || ctrl_fwd_rs2 !== e2) begin
    $display("mismatch %s: expected fwd %0d/%0d actual %0d/%0d", cur_test, e1, e2,
             ctrl_fwd_rs1, ctrl_fwd_rs2);
    errors++;
  end
endtask

task automatic begin_test(input string name);
  cur_test = name;
  err_at_start = errors;
endtask

task automatic end_test();
  drain();
  tests_run++;
  if (errors == err_at_start) begin
    $display("%s: ok", cur_test);
  end else begin
    tests_failed++;
    $display("%s: %0d errors", cur_test, errors - err_at_start);
  end
endtask

task automatic test_reset_addi();
  begin_test("reset_and_addi");
  if (in_ready !== 1'b1 || ctrl_valid !== 1'b0) begin
    $display("%s: in_ready or ctrl_valid has the wrong level after reset", cur_test);
    errors++;
  end
  send(enc(`RV_OPC_ITYPE, 5'd1, `RV_FNC_ADD_SUB, 5'd0, 5'd5, 1'b0));
  end_test();
endtask

task automatic test_alu_decode();
  begin_test("alu_decode");
  for (int f = 0; f < 8; f++) begin
    send(enc(`RV_OPC_RTYPE, 5'd3, 3'(f), 5'd1, 5'd2, 1'b0));
    send(enc(`RV_OPC_ITYPE, 5'd4, 3'(f), 5'd1, 5'd2, 1'b0));
  end
  send(enc(`RV_OPC_RTYPE, 5'd5, `RV_FNC_ADD_SUB, 5'd1, 5'd2, 1'b1));  // SUB
  send(enc(`RV_OPC_RTYPE, 5'd6, `RV_FNC_SRL_SRA, 5'd1, 5'd2, 1'b1));  // SRA
  send(enc(`RV_OPC_ITYPE, 5'd7, `RV_FNC_SRL_SRA, 5'd1, 5'd2, 1'b1));  // SRAI
  send(enc(`RV_OPC_ITYPE, 5'd8, `RV_FNC_ADD_SUB, 5'd1, 5'd2, 1'b1));  // Still ADDI
  end_test();
endtask

task automatic test_other_classes();
  begin_test("other_classes");
  for (int f = 0; f < 8; f++) begin
    send(enc(`RV_OPC_LOAD, 5'd9, 3'(f), 5'd1, 5'd0, 1'b0));
    send(enc(`RV_OPC_BRANCH, 5'd4, 3'(f), 5'd1, 5'd2, 1'b0));
  end
  send(enc(`RV_OPC_STORE, 5'd4, 3'b010, 5'd1, 5'd2, 1'b0));
  send(enc(`RV_OPC_JAL, 5'd1, 3'd0, 5'd3, 5'd3, 1'b0));
  send(enc(`RV_OPC_JALR, 5'd1, 3'd0, 5'd2, 5'd0, 1'b0));
  send(enc(`RV_OPC_AUIPC, 5'd2, 3'd1, 5'd6, 5'd0, 1'b0));
  send(enc(`RV_OPC_LUI, 5'd3, 3'd7, 5'd2, 5'd0, 1'b1));
  send(enc(5'b00011, 5'd7, 3'd0, 5'd3, 5'd7, 1'b0));               // FENCE is unknown here
  end_test();
endtask

task automatic test_forwarding();
  begin_test("forwarding");
  send(enc(`RV_OPC_ITYPE, 5'd5, `RV_FNC_ADD_SUB, 5'd0, 5'd0, 1'b0));
  send(enc(`RV_OPC_RTYPE, 5'd6, `RV_FNC_ADD_SUB, 5'd5, 5'd7, 1'b0));
  chk_fwd(rv_ctrl_pkg::FWD_ALU, rv_ctrl_pkg::FWD_REG);
  send(enc(`RV_OPC_LOAD, 5'd8, `RV_FNC_LW, 5'd1, 5'd0, 1'b0));
  send(enc(`RV_OPC_RTYPE, 5'd9, `RV_FNC_OR, 5'd2, 5'd8, 1'b0));
  chk_fwd(rv_ctrl_pkg::FWD_REG, rv_ctrl_pkg::FWD_MEM);
  send(enc(`RV_OPC_LOAD, 5'd10, `RV_FNC_LW, 5'd1, 5'd0, 1'b0));
  send(enc(`RV_OPC_STORE, 5'd0, 3'b010, 5'd3, 5'd10, 1'b0));
  chk_fwd(rv_ctrl_pkg::FWD_REG, rv_ctrl_pkg::FWD_MEM);
  send(enc(`RV_OPC_ITYPE, 5'd0, `RV_FNC_ADD_SUB, 5'd1, 5'd0, 1'b0));  // Writes x0
  send(enc(`RV_OPC_RTYPE, 5'd11, `RV_FNC_ADD_SUB, 5'd0, 5'd0, 1'b0));
  chk_fwd(rv_ctrl_pkg::FWD_REG, rv_ctrl_pkg::FWD_REG);
  send(enc(`RV_OPC_STORE, 5'd12, 3'b010, 5'd1, 5'd2, 1'b0));          // rd field is imm
  send(enc(`RV_OPC_RTYPE, 5'd13, `RV_FNC_ADD_SUB, 5'd12, 5'd12, 1'b0));
  chk_fwd(rv_ctrl_pkg::FWD_REG, rv_ctrl_pkg::FWD_REG);
  send(enc(`RV_OPC_ITYPE, 5'd14, `RV_FNC_ADD_SUB, 5'd0, 5'd0, 1'b0));
  send(enc(`RV_OPC_ITYPE, 5'd15, `RV_FNC_ADD_SUB, 5'd0, 5'd0, 1'b0));
  send(enc(`RV_OPC_RTYPE, 5'd16, `RV_FNC_ADD_SUB, 5'd14, 5'd14, 1'b0));
  chk_fwd(rv_ctrl_pkg::FWD_REG, rv_ctrl_pkg::FWD_REG);
  end_test();
endtask

task automatic test_credit_limit();
  int t;
  begin_test("credit_limit");
  drain();
  t = 0;
  while (due_q.size() > 0 && t < 20) begin
    @(negedge clk);
    t++;
  end
  if (due_q.size() > 0) begin
    $display("%s: timeout waiting for the credits to come back", cur_test);
    errors++;
  end
  @(negedge clk);                       // Last credit pulse is registered
  hold_credits = 1'b1;
  for (int i = 0; i < `RV_CTRL_CREDITS; i++) begin
    if (!in_ready) begin
      $display("%s: in_ready fell after %0d acceptances", cur_test, i);
      errors++;
    end
    send(enc(`RV_OPC_ITYPE, 5'(i + 1), `RV_FNC_ADD_SUB, 5'(i), 5'd0, 1'b0));
  end
  drain();
  if (in_ready) begin
    $display("%s: in_ready still high with every credit in use", cur_test);
    errors++;
  end
  hold_credits = 1'b0;
  for (int i = 0; i < `RV_CTRL_CREDITS; i++) begin
    send(enc(`RV_OPC_RTYPE, 5'(i + 2), `RV_FNC_XOR, 5'(i + 1), 5'(i), 1'b0));
  end
  end_test();
endtask

task automatic test_random_stream();
  logic [4:0] opcs [10];
  logic [3:0] k;
  opcs = '{`RV_OPC_RTYPE, `RV_OPC_ITYPE, `RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_BRANCH,
           `RV_OPC_JAL, `RV_OPC_JALR, `RV_OPC_AUIPC, `RV_OPC_LUI, 5'b00011};
  begin_test("random_stream");
  for (int i = 0; i < 200; i++) begin
    k = 4'($urandom % 10);
    send(enc(opcs[k], 5'($urandom % 4), 3'($urandom % 8), 5'($urandom % 4),
             5'($urandom % 4), 1'($urandom % 2)));       // Few registers give many hits
  end
  end_test();
endtask

`endif

/* tb_rv_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I control path testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_ctrl_settings.svh"

module tb_rv_ctrl;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  rv_ctrl_pkg::instr_t   in_instr;
  logic                  in_ready;
  logic                  ctrl_credit;
  logic                  ctrl_valid;
  rv_ctrl_pkg::alu_op_t  ctrl_alu_op;
  logic                  ctrl_a_pc;
  logic                  ctrl_b_imm;
  rv_ctrl_pkg::wb_sel_t  ctrl_wb_sel;
  logic                  ctrl_rf_we;
  rv_ctrl_pkg::ldx_t     ctrl_ldx;
  logic                  ctrl_br_un;
  rv_ctrl_pkg::fwd_sel_t ctrl_fwd_rs1;
  rv_ctrl_pkg::fwd_sel_t ctrl_fwd_rs2;
  rv_ctrl_pkg::reg_idx_t ctrl_rd;

  logic [21:0]           exp_q [$];     // Expected words in issue order
  int                    acc_q [$];     // Handshake cycle of each word
  int                    due_q [$];     // Cycle a credit goes back
  int                    cyc = 0;
  int                    errors;
  int                    err_at_start;
  int                    tests_run;
  int                    tests_failed;
  logic                  hold_credits;
  string                 cur_test;
  rv_ctrl_pkg::reg_idx_t m_prev_rd;     // Model of the last accepted insn
  logic                  m_prev_we;
  logic                  m_prev_load;

  rv_ctrl_top DUT (.*);

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // Consumer checks each word and hands its credit back 0..3 cycles later
  always @(negedge clk) begin : consumer
    logic [21:0] got;
    got = {ctrl_alu_op, ctrl_a_pc, ctrl_b_imm, ctrl_wb_sel, ctrl_rf_we, ctrl_ldx,
           ctrl_br_un, ctrl_fwd_rs1, ctrl_fwd_rs2, ctrl_rd};
    ctrl_credit = 1'b0;
    if (!rst && ctrl_valid) begin
      if (exp_q.size() == 0) begin
        $display("%s: control word issued with none expected", cur_test);
        errors++;
      end else begin
        if (got !== exp_q[0]) begin
          $display("mismatch %s: expected %h actual %h", cur_test, exp_q[0], got);
          errors++;
        end
        if (cyc != acc_q[0] + 2) begin
          $display("%s: word came %0d cycles after acceptance", cur_test, cyc - acc_q[0]);
          errors++;
        end
        void'(exp_q.pop_front());
        void'(acc_q.pop_front());
      end
      due_q.push_back(cyc + int'($urandom % 4));
    end
    if (!hold_credits && due_q.size() > 0 && due_q[0] <= cyc) begin
      ctrl_credit = 1'b1;
      void'(due_q.pop_front());
    end
  end

  `include "tb_rv_ctrl_tasks.svh"

  initial begin
    int unsigned seed_init;
    seed_init = $urandom(32'hdf1e_c0b1);
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    ctrl_credit = 1'b0;
    hold_credits = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    m_prev_rd = '0;
    m_prev_we = 1'b0;                   // Reset forgets the last insn
    m_prev_load = 1'b0;
    cur_test = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_addi();
    test_alu_decode();
    test_other_classes();
    test_forwarding();
    test_credit_limit();
    test_random_stream();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* rv_ctrl_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode and forwarding control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv_ctrl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  rv_ctrl_pkg::instr_t   in_instr,
  output logic                  in_ready,
  input  logic                  ctrl_credit,
  output logic                  ctrl_valid,
  output rv_ctrl_pkg::alu_op_t  ctrl_alu_op,
  output logic                  ctrl_a_pc,
  output logic                  ctrl_b_imm,
  output rv_ctrl_pkg::wb_sel_t  ctrl_wb_sel,
  output logic                  ctrl_rf_we,
  output rv_ctrl_pkg::ldx_t     ctrl_ldx,
  output logic                  ctrl_br_un,
  output rv_ctrl_pkg::fwd_sel_t ctrl_fwd_rs1,
  output rv_ctrl_pkg::fwd_sel_t ctrl_fwd_rs2,
  output rv_ctrl_pkg::reg_idx_t ctrl_rd
);

  rv_ctrl_pkg::fwd_sel_t fwd_sel [2];  // Index 0 is rs1

  dec_if dec ();

  insn_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .ctrl_credit (ctrl_credit),
    .in_ready    (in_ready),
    .dec         (dec)
  );

  for (genvar k = 0; k < 2; k++) begin : g_fwd
    operand_forward #(.OPERAND(k)) u_fwd (
      .dec (dec),
      .sel (fwd_sel[k])
    );
  end

  ctrl_issue u_issue (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec),
    .fwd_rs1      (fwd_sel[0]),
    .fwd_rs2      (fwd_sel[1]),
    .ctrl_valid   (ctrl_valid),
    .ctrl_alu_op  (ctrl_alu_op),
    .ctrl_a_pc    (ctrl_a_pc),
    .ctrl_b_imm   (ctrl_b_imm),
    .ctrl_wb_sel  (ctrl_wb_sel),
    .ctrl_rf_we   (ctrl_rf_we),
    .ctrl_ldx     (ctrl_ldx),
    .ctrl_br_un   (ctrl_br_un),
    .ctrl_fwd_rs1 (ctrl_fwd_rs1),
    .ctrl_fwd_rs2 (ctrl_fwd_rs2),
    .ctrl_rd      (ctrl_rd)
  );

endmodule

/* ctrl_issue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control word issue register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ctrl_issue (
  input  logic                  clk,
  input  logic                  rst,
  dec_if.snk                    dec,
  input  rv_ctrl_pkg::fwd_sel_t fwd_rs1,
  input  rv_ctrl_pkg::fwd_sel_t fwd_rs2,
  output logic                  ctrl_valid,
  output rv_ctrl_pkg::alu_op_t  ctrl_alu_op,
  output logic                  ctrl_a_pc,
  output logic                  ctrl_b_imm,
  output rv_ctrl_pkg::wb_sel_t  ctrl_wb_sel,
  output logic                  ctrl_rf_we,
  output rv_ctrl_pkg::ldx_t     ctrl_ldx,
  output logic                  ctrl_br_un,
  output rv_ctrl_pkg::fwd_sel_t ctrl_fwd_rs1,
  output rv_ctrl_pkg::fwd_sel_t ctrl_fwd_rs2,
  output rv_ctrl_pkg::reg_idx_t ctrl_rd
);

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_valid <= 1'b0;
    end else begin
      ctrl_valid <= dec.valid;  // One pulse per decoded word
    end
  end

  always_ff @(posedge clk) begin
    if (dec.valid) begin
      ctrl_alu_op  <= dec.alu_op;
      ctrl_a_pc    <= dec.a_pc;
      ctrl_b_imm   <= dec.b_imm;
      ctrl_wb_sel  <= dec.wb_sel;
      ctrl_rf_we   <= dec.rf_we;
      ctrl_ldx     <= dec.ldx;
      ctrl_br_un   <= dec.br_un;
      ctrl_fwd_rs1 <= fwd_rs1;
      ctrl_fwd_rs2 <= fwd_rs2;
      ctrl_rd      <= dec.rd;
    end
  end

  // A memory write-back is either a real load (base plus offset) or the
  // empty word of an unknown opcode; stores never select memory data
  a_wb_mem: assert property (@(posedge clk) disable iff (rst)
    (ctrl_valid && ctrl_wb_sel == rv_ctrl_pkg::WB_MEM) |->
      (ctrl_rf_we ? (ctrl_b_imm && !ctrl_a_pc) : (!ctrl_b_imm && ctrl_rd == '0)))
    else $error("memory write-back on a word that is neither load nor empty");

endmodule

/* operand_forward.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand forwarding select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_forward #(
  parameter int OPERAND = 0      // 0 picks rs1, 1 picks rs2
) (
  dec_if.snk                    dec,
  output rv_ctrl_pkg::fwd_sel_t sel
);

  rv_ctrl_pkg::reg_idx_t rs;
  logic                  uses;
  logic                  hit;

  assign rs   = (OPERAND == 0) ? dec.rs1 : dec.rs2;
  assign uses = (OPERAND == 0) ? dec.uses_rs1 : dec.uses_rs2;

  // x0 never carries a produced value
  assign hit = uses && (rs != '0) && dec.prev_we && (dec.prev_rd == rs);

  always_comb begin
    if (!hit) begin
      sel = rv_ctrl_pkg::FWD_REG;
    end else if (dec.prev_load) begin
      sel = rv_ctrl_pkg::FWD_MEM;  // Load data wins over ALU path
    end else begin
      sel = rv_ctrl_pkg::FWD_ALU;
    end
  end

endmodule

/* insn_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction accept and decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_ctrl_settings.svh"

module insn_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  rv_ctrl_pkg::instr_t in_instr,
  input  logic                ctrl_credit,
  output logic                in_ready,
  dec_if.src                  dec
);

  rv_ctrl_pkg::credit_t  credits;
  logic                  accept;
  logic [4:0]            opc;
  logic [2:0]            fn3;
  rv_ctrl_pkg::alu_op_t  d_alu_op;
  logic                  d_a_pc;
  logic                  d_b_imm;
  rv_ctrl_pkg::wb_sel_t  d_wb_sel;
  logic                  d_rf_we;
  rv_ctrl_pkg::ldx_t     d_ldx;
  logic                  d_br_un;
  logic                  d_uses_rs1;
  logic                  d_uses_rs2;
  rv_ctrl_pkg::reg_idx_t d_rd;
  rv_ctrl_pkg::reg_idx_t last_rd;     // Last accepted instruction
  logic                  last_we;
  logic                  last_load;

  // R and I share the funct3 map, SUB only exists for R
  function automatic rv_ctrl_pkg::alu_op_t alu_fn(input logic [2:0] f3, input logic alt,
                                                  input logic reg_op);
    case (f3)
      `RV_FNC_ADD_SUB: alu_fn = (alt && reg_op) ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
      `RV_FNC_SLL:     alu_fn = rv_ctrl_pkg::ALU_SLL;
      `RV_FNC_SLT:     alu_fn = rv_ctrl_pkg::ALU_SLT;
      `RV_FNC_SLTU:    alu_fn = rv_ctrl_pkg::ALU_SLTU;
      `RV_FNC_XOR:     alu_fn = rv_ctrl_pkg::ALU_XOR;
      `RV_FNC_SRL_SRA: alu_fn = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
      `RV_FNC_OR:      alu_fn = rv_ctrl_pkg::ALU_OR;
      `RV_FNC_AND:     alu_fn = rv_ctrl_pkg::ALU_AND;
      default:         alu_fn = rv_ctrl_pkg::ALU_ADD;
    endcase
  endfunction

  assign opc      = in_instr[6:2];
  assign fn3      = in_instr[14:12];
  assign in_ready = (credits != '0);  // Credits bound the words in flight
  assign accept   = in_valid && in_ready;

  always_comb begin
    d_alu_op   = rv_ctrl_pkg::ALU_ADD;
    d_a_pc     = 1'b0;
    d_b_imm    = 1'b1;
    d_wb_sel   = rv_ctrl_pkg::WB_ALU;
    d_rf_we    = 1'b1;
    d_ldx      = rv_ctrl_pkg::LDX_W;
    d_br_un    = 1'b0;
    d_uses_rs1 = 1'b1;
    d_uses_rs2 = 1'b0;
    case (opc)
      `RV_OPC_RTYPE: begin
        d_alu_op   = alu_fn(fn3, in_instr[30], 1'b1);
        d_b_imm    = 1'b0;
        d_uses_rs2 = 1'b1;
      end
      `RV_OPC_ITYPE: d_alu_op = alu_fn(fn3, in_instr[30], 1'b0);
      `RV_OPC_LOAD: begin
        d_wb_sel = rv_ctrl_pkg::WB_MEM;
        case (fn3)
          `RV_FNC_LB:  d_ldx = rv_ctrl_pkg::LDX_B;
          `RV_FNC_LH:  d_ldx = rv_ctrl_pkg::LDX_H;
          `RV_FNC_LBU: d_ldx = rv_ctrl_pkg::LDX_BU;
          `RV_FNC_LHU: d_ldx = rv_ctrl_pkg::LDX_HU;
          default:     d_ldx = rv_ctrl_pkg::LDX_W;
        endcase
      end
      `RV_OPC_STORE: begin
        d_rf_we    = 1'b0;       // rd field holds immediate bits
        d_uses_rs2 = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        d_a_pc     = 1'b1;       // Target is PC + imm
        d_rf_we    = 1'b0;
        d_uses_rs2 = 1'b1;
        d_br_un    = (fn3 == `RV_FNC_BLTU) || (fn3 == `RV_FNC_BGEU);
      end
      `RV_OPC_JAL: begin
        d_a_pc     = 1'b1;
        d_wb_sel   = rv_ctrl_pkg::WB_PC4;
        d_uses_rs1 = 1'b0;
      end
      `RV_OPC_JALR:  d_wb_sel = rv_ctrl_pkg::WB_PC4;
      `RV_OPC_AUIPC: begin
        d_a_pc     = 1'b1;
        d_uses_rs1 = 1'b0;
      end
      `RV_OPC_LUI:   d_uses_rs1 = 1'b0;
      default: begin             // Unknown opcode, all-zero word
        d_b_imm    = 1'b0;
        d_wb_sel   = rv_ctrl_pkg::WB_MEM;
        d_rf_we    = 1'b0;
        d_uses_rs1 = 1'b0;
      end
    endcase
  end

  assign d_rd = d_rf_we ? in_instr[11:7] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= rv_ctrl_pkg::credit_t'(`RV_CTRL_CREDITS);
    end else if (accept && !ctrl_credit) begin
      credits <= credits - rv_ctrl_pkg::credit_t'(1);
    end else if (!accept && ctrl_credit) begin
      credits <= credits + rv_ctrl_pkg::credit_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid   <= 1'b0;
      dec.prev_we <= 1'b0;
      last_we     <= 1'b0;
    end else begin
      dec.valid <= accept;
      if (accept) begin
        dec.prev_we <= last_we;
        last_we     <= d_rf_we;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec.rs1       <= in_instr[19:15];
      dec.rs2       <= in_instr[24:20];
      dec.rd        <= d_rd;
      dec.uses_rs1  <= d_uses_rs1;
      dec.uses_rs2  <= d_uses_rs2;
      dec.alu_op    <= d_alu_op;
      dec.a_pc      <= d_a_pc;
      dec.b_imm     <= d_b_imm;
      dec.wb_sel    <= d_wb_sel;
      dec.rf_we     <= d_rf_we;
      dec.ldx       <= d_ldx;
      dec.br_un     <= d_br_un;
      dec.prev_rd   <= last_rd;
      dec.prev_load <= last_load;
      last_rd       <= d_rd;
      last_load     <= (opc == `RV_OPC_LOAD);
    end
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= rv_ctrl_pkg::credit_t'(`RV_CTRL_CREDITS))
    else $error("credit counter above limit");

  // Consumer may only return what was issued
  a_credit_ovf: assert property (@(posedge clk) disable iff (rst)
    ctrl_credit |-> credits != rv_ctrl_pkg::credit_t'(`RV_CTRL_CREDITS))
    else $error("credit returned while counter full");

endmodule

/* dec_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded instruction bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface dec_if;
  logic                  valid;
  rv_ctrl_pkg::reg_idx_t rs1;
  rv_ctrl_pkg::reg_idx_t rs2;
  rv_ctrl_pkg::reg_idx_t rd;         // Zero when nothing is written
  logic                  uses_rs1;
  logic                  uses_rs2;
  rv_ctrl_pkg::alu_op_t  alu_op;
  logic                  a_pc;
  logic                  b_imm;
  rv_ctrl_pkg::wb_sel_t  wb_sel;
  logic                  rf_we;
  rv_ctrl_pkg::ldx_t     ldx;
  logic                  br_un;
  rv_ctrl_pkg::reg_idx_t prev_rd;    // From the instruction accepted before
  logic                  prev_we;
  logic                  prev_load;

  modport src (
    output valid, rs1, rs2, rd, uses_rs1, uses_rs2,
    output alu_op, a_pc, b_imm, wb_sel, rf_we, ldx, br_un,
    output prev_rd, prev_we, prev_load
  );

  modport snk (
    input valid, rs1, rs2, rd, uses_rs1, uses_rs2,
    input alu_op, a_pc, b_imm, wb_sel, rf_we, ldx, br_un,
    input prev_rd, prev_we, prev_load
  );
endinterface

/* rv_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I control path types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "rv_ctrl_settings.svh"

package rv_ctrl_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  fwd_sel_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [2:0]  ldx_t;
  typedef logic [$clog2(`RV_CTRL_CREDITS + 1)-1:0] credit_t;  // Holds 0..CREDITS

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;

  localparam fwd_sel_t FWD_REG = 2'd0;  // Register file value
  localparam fwd_sel_t FWD_ALU = 2'd1;  // Previous ALU result
  localparam fwd_sel_t FWD_MEM = 2'd2;  // Previous load data

  localparam wb_sel_t WB_MEM = 2'd0;
  localparam wb_sel_t WB_ALU = 2'd1;
  localparam wb_sel_t WB_PC4 = 2'd2;

  localparam ldx_t LDX_W  = 3'd0;
  localparam ldx_t LDX_HU = 3'd1;
  localparam ldx_t LDX_H  = 3'd2;
  localparam ldx_t LDX_BU = 3'd3;
  localparam ldx_t LDX_B  = 3'd4;

endpackage

/* rv_ctrl_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I control path settings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RV_CTRL_SETTINGS_SVH
`define RV_CTRL_SETTINGS_SVH

// Opcode field, instruction bits 6:2
`define RV_OPC_RTYPE   5'b01100
`define RV_OPC_ITYPE   5'b00100
`define RV_OPC_LOAD    5'b00000
`define RV_OPC_STORE   5'b01000
`define RV_OPC_BRANCH  5'b11000
`define RV_OPC_JAL     5'b11011
`define RV_OPC_JALR    5'b11001
`define RV_OPC_AUIPC   5'b00101
`define RV_OPC_LUI     5'b01101

// ALU group funct3
`define RV_FNC_ADD_SUB 3'b000
`define RV_FNC_SLL     3'b001
`define RV_FNC_SLT     3'b010
`define RV_FNC_SLTU    3'b011
`define RV_FNC_XOR     3'b100
`define RV_FNC_SRL_SRA 3'b101
`define RV_FNC_OR      3'b110
`define RV_FNC_AND     3'b111

// Load widths
`define RV_FNC_LB      3'b000
`define RV_FNC_LH      3'b001
`define RV_FNC_LW      3'b010
`define RV_FNC_LBU     3'b100
`define RV_FNC_LHU     3'b101

// Branch conditions
`define RV_FNC_BEQ     3'b000
`define RV_FNC_BNE     3'b001
`define RV_FNC_BLT     3'b100
`define RV_FNC_BGE     3'b101
`define RV_FNC_BLTU    3'b110
`define RV_FNC_BGEU    3'b111

`define RV_CTRL_CREDITS 4  // Words the consumer can hold

`endif
